/* src/udp_pkg.sv */
/* udp package
   shared widths, lane vector types, beat structs and runtime config */
`default_nettype none

package udp_pkg;

    ////////////////////////////////////////
    // sizes and limits
    ////////////////////////////////////////
    localparam int UDP_LANES      = 8;
    localparam int UDP_ACC_W      = 32;
    localparam int UDP_Q_W        = 8;
    localparam int UDP_BIAS_DEPTH = 16;
    // holds batch counts 1..16
    localparam int UDP_BATCH_W    = 5;
    localparam int UDP_SHIFT_W    = 5;
    localparam int UDP_BIAS_IDX_W = $clog2(UDP_BIAS_DEPTH);
    localparam int UDP_Q_MAX      = 127;
    localparam int UDP_Q_MIN      = -128;

    // route codes
    localparam logic UDP_ROUTE_QR = 1'b0;
    localparam logic UDP_ROUTE_PQ = 1'b1;

    ////////////////////////////////////////
    // lane vectors and beats
    ////////////////////////////////////////
    // named signed words keep each lane signed on select
    typedef logic signed [UDP_ACC_W-1:0] acc_word_t;
    typedef logic signed [UDP_Q_W-1:0]   q_word_t;
    typedef acc_word_t [UDP_LANES-1:0]   acc_vec_t;
    typedef q_word_t [UDP_LANES-1:0]     q_vec_t;

    typedef struct packed {
        logic     valid;
        acc_vec_t data;
    } acc_beat_t;

    typedef struct packed {
        logic   valid;
        q_vec_t data;
    } q_beat_t;

    // static while data flows
    typedef struct packed {
        logic                          bias_en;
        logic                          route;
        logic [UDP_BATCH_W-1:0]        bias_batch;
        logic signed [UDP_ACC_W-1:0]   quant_mul;
        logic [UDP_SHIFT_W-1:0]        quant_shift;
        logic signed [UDP_ACC_W-1:0]   prelu_slope;
    } udp_cfg_t;

endpackage

`default_nettype wire

/* src/bias_unit.sv */
/* bias unit
   loads a bias buffer, then adds bias vectors lane-wise cycling over a batch */
`timescale 1ns/1ps
`default_nettype none

module bias_unit (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    input  logic                                 i_bias_en,
    input  logic [udp_pkg::UDP_BATCH_W-1:0]      i_batch,
    input  udp_pkg::acc_vec_t                    i_bias_vec,
    input  logic                                 i_bias_valid,
    input  logic                                 i_bias_done,
    input  udp_pkg::acc_beat_t                   i_in,
    output udp_pkg::acc_beat_t                   o_out
);
    import udp_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_READY
    } state_t;

    state_t state_q;
    state_t state_nxt;

    // bias buffer, one vector per entry
    acc_vec_t mem [UDP_BIAS_DEPTH];

    // write index counts up to depth, so one bit wider
    logic [UDP_BIAS_IDX_W:0]   wr_idx;
    logic [UDP_BIAS_IDX_W-1:0] rd_idx;

    logic     load_wr;
    logic     use_rd;
    logic     rd_last;
    acc_vec_t bias_rd;

    // output payload and valid
    acc_vec_t sum_q;
    logic     valid_q;

    ////////////////////////////////////////
    // fsm
    ////////////////////////////////////////
    always_comb begin
        state_nxt = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_bias_en) begin
                    state_nxt = ST_LOAD;
                end
            end
            ST_LOAD: begin
                if (i_bias_done) begin
                    state_nxt = ST_READY;
                end
            end
            ST_READY: begin
                state_nxt = ST_READY;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
        // dropping enable always returns to idle
        if (!i_bias_en) begin
            state_nxt = ST_IDLE;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_nxt;
        end
    end

    ////////////////////////////////////////
    // buffer write side
    ////////////////////////////////////////
    // writes past the last entry are ignored
    assign load_wr = (state_q == ST_LOAD) && i_bias_valid && (wr_idx < UDP_BIAS_DEPTH);

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            wr_idx <= '0;
        end else if (state_q == ST_IDLE) begin
            wr_idx <= '0;
        end else if (load_wr) begin
            wr_idx <= wr_idx + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (load_wr) begin
            mem[wr_idx[UDP_BIAS_IDX_W-1:0]] <= i_bias_vec;
        end
    end

    ////////////////////////////////////////
    // batch read side
    ////////////////////////////////////////
    // inputs outside ready are discarded
    assign use_rd  = (state_q == ST_READY) && i_bias_en && i_in.valid;
    // wrap after batch-1, or at buffer end
    assign rd_last = ({1'b0, rd_idx} == (i_batch - 1'b1))
                   || (rd_idx == UDP_BIAS_IDX_W'(UDP_BIAS_DEPTH - 1));
    assign bias_rd = mem[rd_idx];

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            rd_idx <= '0;
        end else if ((state_q != ST_READY) || !i_bias_en) begin
            // restart batch on every load / done
            rd_idx <= '0;
        end else if (use_rd) begin
            rd_idx <= rd_last ? '0 : rd_idx + 1'b1;
        end
    end

    // lane adds, 32-bit wraparound
    always_ff @(posedge i_clk) begin
        for (int l = 0; l < UDP_LANES; l++) begin
            sum_q[l] <= i_in.data[l] + bias_rd[l];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= use_rd;
        end
    end

    assign o_out = {valid_q, sum_q};

endmodule

`default_nettype wire

/* src/prelu_stage.sv */
/* prelu stage
   scales negative lanes by the slope, passes the rest, one cycle */
`timescale 1ns/1ps
`default_nettype none

module prelu_stage (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    input  logic signed [udp_pkg::UDP_ACC_W-1:0] i_slope,
    input  udp_pkg::acc_beat_t                   i_in,
    output udp_pkg::acc_beat_t                   o_out
);
    import udp_pkg::*;

    acc_vec_t data_q;
    logic     valid_q;

    ////////////////////////////////////////
    // per-lane sign check
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        for (int l = 0; l < UDP_LANES; l++) begin
            if (i_in.data[l][UDP_ACC_W-1]) begin
                // keep low 32 bits of the product
                data_q[l] <= i_in.data[l] * i_slope;
            end else begin
                data_q[l] <= i_in.data[l];
            end
        end
    end

    // valid tracks the data delay
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_in.valid;
        end
    end

    assign o_out = {valid_q, data_q};

endmodule

`default_nettype wire

/* src/quant_stage.sv */
/* quant stage
   per-lane multiply, arithmetic shift and 8-bit saturation, two cycles */
`timescale 1ns/1ps
`default_nettype none

module quant_stage (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    input  logic signed [udp_pkg::UDP_ACC_W-1:0] i_mul,
    input  logic [udp_pkg::UDP_SHIFT_W-1:0]      i_shift,
    input  udp_pkg::acc_beat_t                   i_in,
    output udp_pkg::q_beat_t                     o_out
);
    import udp_pkg::*;

    // stage 1: full-width scaled lanes
    logic signed [2*UDP_ACC_W-1:0] prod_c [UDP_LANES];
    logic signed [2*UDP_ACC_W-1:0] prod_q [UDP_LANES];
    logic                          s1_valid;

    // stage 2: saturated lanes
    q_vec_t sat_q;
    logic   s2_valid;

    always_comb begin
        for (int l = 0; l < UDP_LANES; l++) begin
            // both operands signed, sign extended to 64 bits
            prod_c[l] = $signed(i_in.data[l]) * i_mul;
        end
    end

    always_ff @(posedge i_clk) begin
        for (int l = 0; l < UDP_LANES; l++) begin
            prod_q[l] <= prod_c[l] >>> i_shift;
        end
    end

    ////////////////////////////////////////
    // saturate to [-128, 127]
    ////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        for (int l = 0; l < UDP_LANES; l++) begin
            if (prod_q[l] > UDP_Q_MAX) begin
                sat_q[l] <= q_word_t'(UDP_Q_MAX);
            end else if (prod_q[l] < UDP_Q_MIN) begin
                sat_q[l] <= q_word_t'(UDP_Q_MIN);
            end else begin
                sat_q[l] <= prod_q[l][UDP_Q_W-1:0];
            end
        end
    end

    // two-deep valid pipe
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= i_in.valid;
            s2_valid <= s1_valid;
        end
    end

    assign o_out = {s2_valid, sat_q};

endmodule

`default_nettype wire

/* src/relu_stage.sv */
/* relu stage
   zeroes negative 8-bit lanes, one cycle */
`timescale 1ns/1ps
`default_nettype none

module relu_stage (
    input  logic              i_clk,
    input  logic              i_rst,
    input  udp_pkg::q_beat_t  i_in,
    output udp_pkg::q_beat_t  o_out
);
    import udp_pkg::*;

    q_vec_t data_q;
    logic   valid_q;

    // sign bit picks zero or pass
    always_ff @(posedge i_clk) begin
        for (int l = 0; l < UDP_LANES; l++) begin
            data_q[l] <= i_in.data[l][UDP_Q_W-1] ? q_word_t'(0) : i_in.data[l];
        end
    end

    // vector valid kept, only lanes cleared
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_in.valid;
        end
    end

    assign o_out = {valid_q, data_q};

endmodule

`default_nettype wire

/* src/udp_top.sv */
/* udp top
   bias bypass, route steering over prelu/quant/relu, registered fifo push */
`timescale 1ns/1ps
`default_nettype none

module udp_top (
    input  logic                i_clk,
    input  logic                i_rst,
    input  udp_pkg::udp_cfg_t   i_cfg,
    input  udp_pkg::acc_vec_t   i_bias_vec,
    input  logic                i_bias_valid,
    input  logic                i_bias_done,
    input  udp_pkg::acc_beat_t  i_conv,
    input  logic                i_fifo_full,
    output udp_pkg::q_vec_t     o_data,
    output logic                o_push
);
    import udp_pkg::*;

    // beats at each stage boundary
    acc_beat_t bias_beat;
    acc_beat_t src_beat;
    acc_beat_t prelu_in;
    acc_beat_t prelu_out;
    acc_beat_t quant_in;
    q_beat_t   quant_out;
    q_beat_t   relu_in;
    q_beat_t   relu_out;
    q_beat_t   final_beat;

    // output register, valid doubles as push
    q_beat_t   out_q;

    ////////////////////////////////////////
    // bias stage, skipped when disabled
    ////////////////////////////////////////
    bias_unit bias_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_bias_en    (i_cfg.bias_en),
        .i_batch      (i_cfg.bias_batch),
        .i_bias_vec   (i_bias_vec),
        .i_bias_valid (i_bias_valid),
        .i_bias_done  (i_bias_done),
        .i_in         (i_conv),
        .o_out        (bias_beat)
    );

    ////////////////////////////////////////
    // route steering
    ////////////////////////////////////////
    always_comb begin
        // bypass adds no cycles
        src_beat = i_cfg.bias_en ? bias_beat : i_conv;

        // prelu only sees beats on route 1
        prelu_in       = src_beat;
        prelu_in.valid = src_beat.valid && (i_cfg.route == UDP_ROUTE_PQ);

        // relu only sees beats on route 0
        relu_in       = quant_out;
        relu_in.valid = quant_out.valid && (i_cfg.route == UDP_ROUTE_QR);

        if (i_cfg.route == UDP_ROUTE_PQ) begin
            // prelu -> quant -> out
            quant_in   = prelu_out;
            final_beat = quant_out;
        end else begin
            // quant -> relu -> out
            quant_in   = src_beat;
            final_beat = relu_out;
        end
    end

    prelu_stage prelu_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_slope (i_cfg.prelu_slope),
        .i_in    (prelu_in),
        .o_out   (prelu_out)
    );

    // single quant instance shared by both routes
    quant_stage quant_i (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_mul   (i_cfg.quant_mul),
        .i_shift (i_cfg.quant_shift),
        .i_in    (quant_in),
        .o_out   (quant_out)
    );

    relu_stage relu_i (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_in  (relu_in),
        .o_out (relu_out)
    );

    ////////////////////////////////////////
    // output register and push
    ////////////////////////////////////////
    // full fifo drops the vector, no stall
    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            out_q.valid <= 1'b0;
        end else begin
            out_q.valid <= final_beat.valid && !i_fifo_full;
        end
    end

    // data follows every final valid, even when dropped
    always_ff @(posedge i_clk) begin
        if (final_beat.valid) begin
            out_q.data <= final_beat.data;
        end
    end

    assign o_data = out_q.data;
    assign o_push = out_q.valid;

endmodule

`default_nettype wire

/* bench/udp_checker.sv */
/* udp checker
   bound assertions on the fifo push and on reset behavior */
`timescale 1ns/1ps
`default_nettype none

module udp_checker (
    input logic                i_clk,
    input logic                i_rst,
    input udp_pkg::udp_cfg_t   i_cfg,
    input logic                i_fifo_full,
    input udp_pkg::q_vec_t     i_data,
    input logic                i_push
);
    import udp_pkg::*;

    // all lanes clear of the sign bit
    function automatic logic lanes_non_negative(input q_vec_t v);
        logic ok;
        ok = 1'b1;
        for (int l = 0; l < UDP_LANES; l++) begin
            if (v[l][UDP_Q_W-1]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    ////////////////////////////////////////
    // properties
    ////////////////////////////////////////
    // push register cleared by reset
    push_quiet_after_reset: assert property (@(posedge i_clk) !i_rst |=> !i_push)
        else $error("push high in the cycle after reset");

    // a full fifo in the deciding cycle blocks the push
    push_needs_room: assert property (@(posedge i_clk) disable iff (!i_rst)
        i_push |-> !$past(i_fifo_full))
        else $error("push issued while the fifo was full");

    // relu on route 0 leaves no negative lane
    route0_non_negative: assert property (@(posedge i_clk) disable iff (!i_rst)
        (i_push && i_cfg.route == UDP_ROUTE_QR) |-> lanes_non_negative(i_data))
        else $error("negative lane pushed on route 0");

endmodule

bind udp_top udp_checker chk_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_cfg       (i_cfg),
    .i_fifo_full (i_fifo_full),
    .i_data      (o_data),
    .i_push      (o_push)
);

`default_nettype wire

/* bench/udp_tb.sv */
/* udp testbench
   directed tests, lcg lane source, queue based reference model and watchdog */
`timescale 1ns/1ps
`default_nettype none

module udp_tb;
    import udp_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int HALF_PERIOD = CLK_PERIOD / 2;
    localparam int N_RAND      = 24;
    localparam int N_BP        = 12;
    localparam int N_BIAS      = 9;
    // vectors issued over all tests
    localparam int TOTAL_VECS      = 2 * N_RAND + 4 + N_BP + 2 + 2 + N_BIAS;
    localparam int WATCHDOG_CYCLES = TOTAL_VECS * 20 + 200;
    // input slots that meet a full fifo
    localparam logic [N_BP-1:0] BP_MASK = 12'b0100_1100_0010;

    logic      clk;
    logic      rst;
    udp_cfg_t  cfg;
    acc_vec_t  bias_vec;
    logic      bias_valid;
    logic      bias_done;
    acc_beat_t conv;
    logic      fifo_full;
    q_vec_t    out_data;
    logic      out_push;

    // reference model state
    udp_cfg_t    model_cfg;
    acc_vec_t    bias_mem [UDP_BIAS_DEPTH];
    int          bias_ptr;
    logic        bias_ready;
    q_vec_t      exp_q [$];
    q_vec_t      exp_head;
    logic [31:0] lcg_state = 32'd7671;
    int          errors;
    int          checks;
    int          push_count;
    time         last_push_time;

    udp_top dut_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .i_cfg        (cfg),
        .i_bias_vec   (bias_vec),
        .i_bias_valid (bias_valid),
        .i_bias_done  (bias_done),
        .i_conv       (conv),
        .i_fifo_full  (fifo_full),
        .o_data       (out_data),
        .o_push       (out_push)
    );

    always #HALF_PERIOD clk = ~clk;

    ////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // about +-32k, keeps most results inside 8 bits
    function automatic acc_word_t random_lane();
        logic [31:0] r;
        r = lcg_next();
        return {{16{r[30]}}, r[30:15]};
    endfunction

    function automatic acc_vec_t random_vector();
        acc_vec_t v;
        for (int l = 0; l < UDP_LANES; l++) begin
            v[l] = random_lane();
        end
        return v;
    endfunction

    // negative lanes take low 32 bits of x*slope
    function automatic acc_word_t prelu_model(input acc_word_t x, input acc_word_t slope);
        logic signed [63:0] p;
        p = {{32{x[31]}}, x} * {{32{slope[31]}}, slope};
        return x[31] ? p[31:0] : x;
    endfunction

    // full product, arithmetic shift, clamp to 8 bits
    function automatic q_word_t quant_model(input acc_word_t x, input acc_word_t mul,
                                            input logic [4:0] shift);
        logic signed [63:0] p;
        p = {{32{x[31]}}, x} * {{32{mul[31]}}, mul};
        p = p >>> shift;
        if (p > 64'sd127) begin
            return 8'sd127;
        end else if (p < -64'sd128) begin
            return -8'sd128;
        end
        return p[7:0];
    endfunction

    function automatic q_word_t relu_model(input q_word_t q);
        return q[7] ? 8'sd0 : q;
    endfunction

    function automatic q_vec_t expected_vector(input acc_vec_t x);
        q_vec_t  y;
        acc_word_t a;
        for (int l = 0; l < UDP_LANES; l++) begin
            a = x[l];
            if (model_cfg.route == UDP_ROUTE_PQ) begin
                a = prelu_model(a, model_cfg.prelu_slope);
            end
            y[l] = quant_model(a, model_cfg.quant_mul, model_cfg.quant_shift);
            if (model_cfg.route == UDP_ROUTE_QR) begin
                y[l] = relu_model(y[l]);
            end
        end
        return y;
    endfunction

    // bias applies before a possible drop at the fifo
    task automatic queue_expected(input acc_vec_t v, input logic dropped);
        acc_vec_t x;
        x = v;
        if (model_cfg.bias_en) begin
            // unloaded buffer discards the input
            if (!bias_ready) begin
                return;
            end
            for (int l = 0; l < UDP_LANES; l++) begin
                x[l] = v[l] + bias_mem[bias_ptr][l];
            end
            bias_ptr = (bias_ptr == int'(model_cfg.bias_batch) - 1) ? 0 : bias_ptr + 1;
        end
        if (!dropped) begin
            exp_q.push_back(expected_vector(x));
        end
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // drive helpers
    ////////////////////////////////////////
    task automatic drive_cycle(input logic valid, input acc_vec_t data, input logic full);
        @(posedge clk);
        conv.valid <= valid;
        conv.data  <= data;
        fifo_full  <= full;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, '0, 1'b0);
    endtask

    task automatic send_vector(input acc_vec_t v);
        drive_cycle(1'b1, v, 1'b0);
        queue_expected(v, 1'b0);
    endtask

    task automatic apply_cfg(input logic en, input logic route, input logic [4:0] batch,
                             input logic signed [31:0] mul, input logic [4:0] shift,
                             input logic signed [31:0] slope);
        udp_cfg_t c;
        c.bias_en     = en;
        c.route       = route;
        c.bias_batch  = batch;
        c.quant_mul   = mul;
        c.quant_shift = shift;
        c.prelu_slope = slope;
        @(posedge clk);
        cfg       <= c;
        model_cfg = c;
    endtask

    // wait out the queue, then a quiet window for stray pushes
    task automatic drain_pipeline();
        int waited;
        idle_cycle();
        waited = 0;
        while (exp_q.size() != 0 && waited < 30) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("Error: %0d expected vectors never arrived at the output", exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (6) @(posedge clk);
    endtask

    task automatic report_test(input string label, input int err_start);
        $display("[%0t ns] %s finished, %0d errors", $time, label, errors - err_start);
    endtask

    ////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////
    task automatic route0_no_bias();
        int err_start;
        err_start = errors;
        apply_cfg(1'b0, UDP_ROUTE_QR, 5'd1, 32'sd3, 5'd10, 32'sd5);
        repeat (N_RAND) send_vector(random_vector());
        drain_pipeline();
        report_test("route 0 without bias", err_start);
    endtask

    task automatic route1_no_bias();
        int err_start;
        err_start = errors;
        apply_cfg(1'b0, UDP_ROUTE_PQ, 5'd1, 32'sd3, 5'd10, 32'sd5);
        repeat (N_RAND) send_vector(random_vector());
        drain_pipeline();
        report_test("route 1 without bias", err_start);
    endtask

    // small shift pushes big lanes past both limits
    task automatic saturation_both_routes();
        acc_vec_t v;
        int       err_start;
        err_start = errors;
        for (int r = 0; r < 2; r++) begin
            apply_cfg(1'b0, r[0], 5'd1, 32'sd16, 5'd2, 32'sd5);
            v[0] = 32'sh1000_0000;
            v[1] = -32'sh1000_0000;
            v[2] = 32'sh0100_0000;
            v[3] = -32'sh0100_0000;
            v[4] = 32'sd100;
            v[5] = -32'sd100;
            v[6] = 32'sd40;
            v[7] = -32'sd40;
            send_vector(v);
            for (int l = 0; l < UDP_LANES; l++) begin
                v[l] = -v[l];
            end
            send_vector(v);
            drain_pipeline();
        end
        report_test("saturation", err_start);
    endtask

    task automatic backpressure_drops();
        acc_vec_t v;
        logic     full;
        int       err_start;
        err_start = errors;
        apply_cfg(1'b0, UDP_ROUTE_QR, 5'd1, 32'sd3, 5'd10, 32'sd5);
        // full lines up with the final valid, three edges after the drive
        for (int c = 0; c < N_BP + 3; c++) begin
            full = (c >= 3) ? BP_MASK[c-3] : 1'b0;
            if (c < N_BP) begin
                v = random_vector();
                drive_cycle(1'b1, v, full);
                queue_expected(v, BP_MASK[c]);
            end else begin
                drive_cycle(1'b0, '0, full);
            end
        end
        drain_pipeline();
        report_test("backpressure", err_start);
    endtask

    // cycles from the drive edge to the push edge
    task automatic push_latency(input int exp_cycles, input string label);
        acc_vec_t    v;
        time         t0;
        logic [63:0] cycles;
        int          start_count;
        int          waited;
        int          err_start;
        err_start   = errors;
        v           = random_vector();
        start_count = push_count;
        drive_cycle(1'b1, v, 1'b0);
        t0 = $time;
        queue_expected(v, 1'b0);
        idle_cycle();
        waited = 0;
        while (push_count == start_count && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (push_count == start_count) begin
            $display("Error: no push followed the single input in %s", label);
            errors++;
        end else begin
            cycles = (last_push_time - t0 - HALF_PERIOD) / CLK_PERIOD;
            compare_value("o_push latency", cycles, 64'(exp_cycles));
        end
        drain_pipeline();
        report_test(label, err_start);
    endtask

    task automatic bias_batch_wrap();
        acc_vec_t bv;
        int       err_start;
        err_start  = errors;
        bias_ready = 1'b0;
        bias_ptr   = 0;
        apply_cfg(1'b1, UDP_ROUTE_QR, 5'd3, 32'sd3, 5'd10, 32'sd5);
        // idle -> load
        repeat (2) idle_cycle();
        for (int i = 0; i < 4; i++) begin
            bv = random_vector();
            bias_mem[i] = bv;
            @(posedge clk);
            bias_vec   <= bv;
            bias_valid <= 1'b1;
            // two inputs during load, both discarded
            conv.valid <= (i < 2);
            conv.data  <= random_vector();
        end
        @(posedge clk);
        bias_valid <= 1'b0;
        conv.valid <= 1'b0;
        bias_done  <= 1'b1;
        @(posedge clk);
        bias_done  <= 1'b0;
        bias_ready = 1'b1;
        repeat (N_BIAS) send_vector(random_vector());
        drain_pipeline();
        report_test("bias load and batch wrap", err_start);
    endtask

    ////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rst && out_push) begin
            push_count++;
            last_push_time = $time;
            if (exp_q.size() == 0) begin
                errors++;
                $display("Error at %0t ns: push arrived with no vector expected", $time);
            end else begin
                exp_head = exp_q.pop_front();
                compare_value("o_data", out_data, exp_head);
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b0;
        cfg        = '0;
        bias_vec   = '0;
        bias_valid = 1'b0;
        bias_done  = 1'b0;
        conv       = '0;
        fifo_full  = 1'b0;
        model_cfg  = '0;
        bias_ready = 1'b0;
        bias_ptr   = 0;
        errors     = 0;
        checks     = 0;
        push_count = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);

        route0_no_bias();
        route1_no_bias();
        saturation_both_routes();
        backpressure_drops();
        push_latency(4, "latency without bias");
        bias_batch_wrap();
        push_latency(5, "latency with bias");

        $display("summary: %0d checks, %0d errors, %0d pushes", checks, errors, push_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* udp_top.f */
src/udp_pkg.sv
src/bias_unit.sv
src/prelu_stage.sv
src/quant_stage.sv
src/relu_stage.sv
src/udp_top.sv
bench/udp_checker.sv
bench/udp_tb.sv

/* Makefile */
# verilator build and run for the udp testbench
VERILATOR ?= verilator
TOP       ?= udp_tb
FILELIST  ?= udp_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
